// File: ahb_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared AHB-Lite types and address map. Single master, word accesses only
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package ahb_pkg;

    // Transfer type as driven by the master on htrans
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_t;

    // Satellite that owns the current data phase
    typedef enum logic {
        SEL_DEFAULT = 1'b0,
        SEL_UART    = 1'b1
    } sel_t;

    localparam logic [31:0] UART_BASE = 32'h2002_0000;
    localparam logic [31:0] UART_SPAN = 32'd16;  // Window size in bytes

    // Word offsets inside the UART window
    localparam logic [3:0] UART_TXDATA  = 4'h0;
    localparam logic [3:0] UART_STATUS  = 4'h4;  // Bit 0 is busy
    localparam logic [3:0] UART_BAUDDIV = 4'h8;  // Clocks per bit
    localparam logic [3:0] UART_SCRATCH = 4'hC;

    localparam logic [15:0] UART_DIV_RESET = 16'd4;
    localparam int UART_FRAME_BITS = 10;  // Start, 8 data, stop

endpackage

`default_nettype wire

// File: ahb_multiplexor.sv
////////////////////////////////////////////////////////////////////////////
// Two satellites only. Anything outside the UART window goes to the
// default slave, and so does every IDLE cycle
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module ahb_multiplexor
    import ahb_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic [31:0] haddr,
    input  htrans_t     htrans,
    input  logic [31:0] hrdata_def,
    input  logic        hreadyout_def,
    input  hresp_t      hresp_def,
    input  logic [31:0] hrdata_uart,
    input  logic        hreadyout_uart,
    input  hresp_t      hresp_uart,
    output logic        hsel_def,
    output logic        hsel_uart,
    output logic [31:0] hrdata,
    output logic        hready,
    output hresp_t      hresp
);

    sel_t sel_d;  // Selection for the current address phase
    sel_t sel_q;  // Selection owning the data phase
    logic in_uart;

    // Address window check, upper bound exclusive
    assign in_uart = (haddr >= UART_BASE) && (haddr < (UART_BASE + UART_SPAN));

    always_comb begin
        if (htrans != IDLE && in_uart) begin
            sel_d = SEL_UART;
        end else begin
            sel_d = SEL_DEFAULT;
        end
    end

    assign hsel_uart = (sel_d == SEL_UART);
    assign hsel_def  = (sel_d == SEL_DEFAULT);

    // Selection advances only when the previous data phase is done
    always_ff @(posedge clk) begin
        if (!nrst) begin
            sel_q <= SEL_DEFAULT;
        end else if (hready) begin
            sel_q <= sel_d;
        end
    end

    // Response steering from the data-phase owner
    always_comb begin
        case (sel_q)
            SEL_UART: begin
                hrdata = hrdata_uart;
                hready = hreadyout_uart;
                hresp  = hresp_uart;
            end
            default: begin
                hrdata = hrdata_def;
                hready = hreadyout_def;
                hresp  = hresp_def;
            end
        endcase
    end

    // Exactly one satellite sees each address phase
    a_sel_onehot: assert property (
        @(posedge clk) disable iff (!nrst)
        $onehot({hsel_def, hsel_uart})
    ) else $error("Both or neither satellite selected");

endmodule

`default_nettype wire

// File: ahb_default_slave.sv
////////////////////////////////////////////////////////////////////////////
// Answers every real transfer with the two-cycle ERROR response
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module ahb_default_slave
    import ahb_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        hsel,
    input  htrans_t     htrans,
    input  logic        hready_in,
    output logic        hreadyout,
    output hresp_t      hresp,
    output logic [31:0] hrdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ERR1,  // First error cycle, wait state
        ST_ERR2   // Second error cycle, transfer ends
    } state_t;

    state_t state_q, state_d;
    logic   capture;

    // Real transfer addressed to us
    assign capture = hsel && hready_in && (htrans == NONSEQ || htrans == SEQ);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_ERR1: state_d = ST_ERR2;
            default: state_d = capture ? ST_ERR1 : ST_IDLE;  // IDLE and ERR2
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign hreadyout = (state_q != ST_ERR1);
    assign hresp     = (state_q == ST_IDLE) ? OKAY : ERROR;
    assign hrdata    = '0;

    a_err_seq: assert property (
        @(posedge clk) disable iff (!nrst)
        (hresp == ERROR && hreadyout) |-> $past(hresp == ERROR && !hreadyout)
    ) else $error("ERROR completed without its wait cycle");

endmodule

`default_nettype wire

// File: uart_tx_slave.sv
////////////////////////////////////////////////////////////////////////////
// 8N1 transmitter. BAUDDIV must be nonzero and stay unchanged during a frame
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module uart_tx_slave
    import ahb_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        hsel,
    input  logic [3:0]  haddr,
    input  htrans_t     htrans,
    input  logic        hwrite,
    input  logic [31:0] hwdata,
    input  logic        hready_in,
    output logic [31:0] hrdata,
    output logic        hreadyout,
    output hresp_t      hresp,
    output logic        uart_tx
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    // Registered address phase
    logic       act_q;
    logic       wr_q;
    logic [3:0] addr_q;

    // Registers
    logic [15:0] baud_div_q;
    logic [31:0] scratch_q;
    logic [7:0]  tx_byte_q;  // Last byte sent

    tx_state_t   tx_state_q;
    logic [15:0] baud_cnt_q;
    logic [2:0]  bit_cnt_q;
    logic [7:0]  shift_q;

    logic busy, bit_done, wr_en, tx_load;

    assign busy     = (tx_state_q != TX_IDLE);
    assign bit_done = (baud_cnt_q == baud_div_q - 16'd1);

    // Stall a TXDATA write until the current frame is out
    assign hreadyout = !(act_q && wr_q && addr_q == UART_TXDATA && busy);
    assign hresp     = OKAY;
    assign wr_en     = act_q && wr_q && hreadyout;
    assign tx_load   = wr_en && (addr_q == UART_TXDATA);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            act_q <= 1'b0;
        end else if (hready_in) begin
            act_q <= hsel && (htrans == NONSEQ || htrans == SEQ);
        end
    end

    always_ff @(posedge clk) begin
        if (hready_in) begin
            wr_q   <= hwrite;
            addr_q <= haddr;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            baud_div_q <= UART_DIV_RESET;
            scratch_q  <= '0;
        end else if (wr_en) begin
            if (addr_q == UART_BAUDDIV) baud_div_q <= hwdata[15:0];
            if (addr_q == UART_SCRATCH) scratch_q <= hwdata;
        end
    end

    // Read mux, zero for writes and unaligned offsets
    always_comb begin
        hrdata = '0;
        if (act_q && !wr_q) begin
            case (addr_q)
                UART_TXDATA:  hrdata = {24'd0, tx_byte_q};
                UART_STATUS:  hrdata = {31'd0, busy};
                UART_BAUDDIV: hrdata = {16'd0, baud_div_q};
                UART_SCRATCH: hrdata = scratch_q;
                default:      hrdata = '0;
            endcase
        end
    end

    // Transmit FSM, each bit held for baud_div_q clocks
    always_ff @(posedge clk) begin
        if (!nrst) begin
            tx_state_q <= TX_IDLE;
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            tx_byte_q  <= '0;
        end else begin
            case (tx_state_q)
                TX_IDLE: begin
                    if (tx_load) begin
                        tx_state_q <= TX_START;
                        baud_cnt_q <= '0;
                        tx_byte_q  <= hwdata[7:0];
                    end
                end
                TX_START: begin
                    baud_cnt_q <= bit_done ? '0 : baud_cnt_q + 16'd1;
                    if (bit_done) begin
                        tx_state_q <= TX_DATA;
                        bit_cnt_q  <= '0;
                    end
                end
                TX_DATA: begin
                    baud_cnt_q <= bit_done ? '0 : baud_cnt_q + 16'd1;
                    if (bit_done) begin
                        bit_cnt_q <= bit_cnt_q + 3'd1;
                        if (bit_cnt_q == 3'd7) tx_state_q <= TX_STOP;
                    end
                end
                default: begin  // Stop bit
                    baud_cnt_q <= bit_done ? '0 : baud_cnt_q + 16'd1;
                    if (bit_done) tx_state_q <= TX_IDLE;
                end
            endcase
        end
    end

    // LSB first shifter
    always_ff @(posedge clk) begin
        if (tx_load) begin
            shift_q <= hwdata[7:0];
        end else if (tx_state_q == TX_DATA && bit_done) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    assign uart_tx = (tx_state_q == TX_START) ? 1'b0 :
                     (tx_state_q == TX_DATA)  ? shift_q[0] : 1'b1;

    a_stall_busy: assert property (
        @(posedge clk) disable iff (!nrst)
        !hreadyout |-> busy
    ) else $error("Wait state with idle transmitter");

    // A released write always launches the next frame
    a_stall_release: assert property (
        @(posedge clk) disable iff (!nrst)
        $rose(hreadyout) |=> (tx_state_q == TX_START)
    ) else $error("Stalled TXDATA write did not start a frame");

endmodule

`default_nettype wire

// File: ahb_subsystem_top.sv
////////////////////////////////////////////////////////////////////////////
// Single-master AHB-Lite subsystem, UART at 0x2002_0000, error elsewhere
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module ahb_subsystem_top
    import ahb_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic [31:0] haddr,
    input  htrans_t     htrans,
    input  logic        hwrite,
    input  logic [31:0] hwdata,
    output logic [31:0] hrdata,
    output logic        hready,
    output hresp_t      hresp,
    output logic        uart_tx
);

    logic        hsel_def, hsel_uart;
    logic [31:0] hrdata_def, hrdata_uart;
    logic        hreadyout_def, hreadyout_uart;
    hresp_t      hresp_def, hresp_uart;

    ahb_multiplexor u_mux (
        .clk            (clk),
        .nrst           (nrst),
        .haddr          (haddr),
        .htrans         (htrans),
        .hrdata_def     (hrdata_def),
        .hreadyout_def  (hreadyout_def),
        .hresp_def      (hresp_def),
        .hrdata_uart    (hrdata_uart),
        .hreadyout_uart (hreadyout_uart),
        .hresp_uart     (hresp_uart),
        .hsel_def       (hsel_def),
        .hsel_uart      (hsel_uart),
        .hrdata         (hrdata),
        .hready         (hready),
        .hresp          (hresp)
    );

    ahb_default_slave u_def (
        .clk       (clk),
        .nrst      (nrst),
        .hsel      (hsel_def),
        .htrans    (htrans),
        .hready_in (hready),
        .hreadyout (hreadyout_def),
        .hresp     (hresp_def),
        .hrdata    (hrdata_def)
    );

    // Only the word offset inside the window reaches the UART
    uart_tx_slave u_uart (
        .clk       (clk),
        .nrst      (nrst),
        .hsel      (hsel_uart),
        .haddr     (haddr[3:0]),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hwdata    (hwdata),
        .hready_in (hready),
        .hrdata    (hrdata_uart),
        .hreadyout (hreadyout_uart),
        .hresp     (hresp_uart),
        .uart_tx   (uart_tx)
    );

endmodule

`default_nettype wire

// File: tb_ahb_subsystem.sv
////////////////////////////////////////////////////////////////////////////
// Single pipelined master. Serial checks assume BAUDDIV of at least 2
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_ahb_subsystem
    import ahb_pkg::*;
();

    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rdata;  // Compared on OKAY reads only
        hresp_t      resp;
        int          waits;  // Negative means at least one
    } xfer_t;

    logic        clk;
    logic        nrst;
    logic [31:0] haddr;
    htrans_t     htrans;
    logic        hwrite;
    logic [31:0] hwdata;
    logic [31:0] hrdata;
    logic        hready;
    hresp_t      hresp;
    logic        uart_tx;

    xfer_t       xfers[$];
    logic [7:0]  exp_bytes[$];  // Bytes still to appear on uart_tx
    logic [15:0] baud_div;      // Last BAUDDIV written by the master
    logic [15:0] max_div;
    logic        table_ready;
    integer      seed;

    ahb_subsystem_top DUT (
        .clk     (clk),
        .nrst    (nrst),
        .haddr   (haddr),
        .htrans  (htrans),
        .hwrite  (hwrite),
        .hwdata  (hwdata),
        .hrdata  (hrdata),
        .hready  (hready),
        .hresp   (hresp),
        .uart_tx (uart_tx)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic print_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("Checks failed");
    endtask

    function automatic logic [31:0] uart_addr(input logic [3:0] offset);
        return UART_BASE + {28'd0, offset};
    endfunction

    task automatic add_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [31:0] rdata, input hresp_t resp, input int waits);
        xfer_t x;
        x = '{wr, addr, wdata, rdata, resp, waits};
        xfers.push_back(x);
    endtask

    task automatic build_table();
        logic [31:0] rnd0;
        logic [31:0] rnd1;
        seed = 40;
        rnd0 = $random(seed);
        rnd1 = $random(seed);
        // Reset values
        add_xfer(1'b0, uart_addr(UART_BAUDDIV), 32'd0, {16'd0, UART_DIV_RESET}, OKAY, 0);
        add_xfer(1'b0, uart_addr(UART_SCRATCH), 32'd0, 32'd0, OKAY, 0);
        add_xfer(1'b0, uart_addr(UART_STATUS), 32'd0, 32'd0, OKAY, 0);
        // Register access
        add_xfer(1'b1, uart_addr(UART_SCRATCH), rnd0, 32'd0, OKAY, 0);
        add_xfer(1'b0, uart_addr(UART_SCRATCH), 32'd0, rnd0, OKAY, 0);
        add_xfer(1'b1, uart_addr(UART_SCRATCH), rnd1, 32'd0, OKAY, 0);
        add_xfer(1'b0, uart_addr(UART_SCRATCH), 32'd0, rnd1, OKAY, 0);
        add_xfer(1'b1, uart_addr(UART_BAUDDIV), 32'd5, 32'd0, OKAY, 0);
        add_xfer(1'b0, uart_addr(UART_BAUDDIV), 32'd0, 32'd5, OKAY, 0);
        // Unmapped, first one just past the window
        add_xfer(1'b0, UART_BASE + UART_SPAN, 32'd0, 32'd0, ERROR, 1);
        add_xfer(1'b1, 32'h0000_1000, 32'hDEAD_BEEF, 32'd0, ERROR, 1);
        add_xfer(1'b0, uart_addr(UART_SCRATCH), 32'd0, rnd1, OKAY, 0);
        // Serial output, second byte hits a busy transmitter
        add_xfer(1'b1, uart_addr(UART_TXDATA), 32'h0000_00A5, 32'd0, OKAY, 0);
        add_xfer(1'b0, uart_addr(UART_STATUS), 32'd0, 32'd1, OKAY, 0);
        add_xfer(1'b1, uart_addr(UART_TXDATA), 32'h0000_003C, 32'd0, OKAY, -1);
        add_xfer(1'b0, uart_addr(UART_STATUS), 32'd0, 32'd1, OKAY, 0);
        add_xfer(1'b0, uart_addr(UART_TXDATA), 32'd0, 32'h0000_003C, OKAY, 0);
        max_div = UART_DIV_RESET;
        foreach (xfers[k]) begin
            if (xfers[k].wr && xfers[k].addr == uart_addr(UART_BAUDDIV) &&
                xfers[k].wdata[15:0] > max_div) begin
                max_div = xfers[k].wdata[15:0];
            end
        end
    endtask

    // Main master, address phase of entry i overlaps data phase of entry i-1
    initial begin
        int    n_wait;
        xfer_t cur;
        table_ready = 1'b0;
        nrst     = 1'b0;
        haddr    = '0;
        htrans   = IDLE;
        hwrite   = 1'b0;
        hwdata   = '0;
        baud_div = UART_DIV_RESET;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(negedge clk);
        nrst = 1'b1;
        assert (hready && hresp == OKAY) else begin
            print_error("bus not ready with OKAY after reset");
            $fatal(1);
        end
        for (int i = 0; i <= xfers.size(); i++) begin
            @(negedge clk);
            if (i < xfers.size()) begin
                haddr  = xfers[i].addr;
                htrans = NONSEQ;
                hwrite = xfers[i].wr;
            end else begin
                htrans = IDLE;  // Bus parks after the last transfer
                hwrite = 1'b0;
            end
            if (i > 0) begin
                cur    = xfers[i-1];
                hwdata = cur.wdata;
                if (cur.wr && cur.addr == uart_addr(UART_TXDATA)) begin
                    exp_bytes.push_back(cur.wdata[7:0]);
                end
                n_wait = 0;
                while (!hready) begin
                    assert (hresp == cur.resp) else begin
                        print_error($sformatf("addr %h wait state hresp %s", cur.addr,
                                              hresp.name()));
                        $fatal(1);
                    end
                    n_wait++;
                    @(negedge clk);
                end
                assert (hresp == cur.resp) else begin
                    print_error($sformatf("addr %h hresp %s, expected %s", cur.addr,
                                          hresp.name(), cur.resp.name()));
                    $fatal(1);
                end
                assert (cur.wr || cur.resp == ERROR || hrdata == cur.rdata) else begin
                    print_error($sformatf("addr %h read %h, expected %h", cur.addr, hrdata,
                                          cur.rdata));
                    $fatal(1);
                end
                assert (cur.waits < 0 ? n_wait > 0 : n_wait == cur.waits) else begin
                    print_error($sformatf("addr %h took %0d wait states, expected %0d",
                                          cur.addr, n_wait, cur.waits));
                    $fatal(1);
                end
                if (cur.wr && cur.addr == uart_addr(UART_BAUDDIV)) begin
                    baud_div = cur.wdata[15:0];
                end
            end
        end
        while (exp_bytes.size() != 0) @(posedge clk);  // Let the last frame finish
        $display("All checks passed");
        $finish;
    end

    // Serial monitor, samples each bit in its middle on a falling clock
    initial begin
        logic [9:0]  frame;
        logic [15:0] div;
        wait (nrst === 1'b1);
        forever begin
            @(negedge uart_tx);
            div = baud_div;
            repeat (div / 2 + 1) @(negedge clk);
            frame[0] = uart_tx;
            for (int b = 1; b < UART_FRAME_BITS; b++) begin
                repeat (div) @(negedge clk);
                frame[b] = uart_tx;
            end
            assert (exp_bytes.size() != 0) else begin
                print_error($sformatf("serial frame %b with no byte written", frame));
                $fatal(1);
            end
            assert (frame == {1'b1, exp_bytes[0], 1'b0}) else begin
                print_error($sformatf("serial frame %b, expected byte %h", frame,
                                      exp_bytes[0]));
                $fatal(1);
            end
            void'(exp_bytes.pop_front());
        end
    end

    // Watchdog sized from the table and the slowest baud rate in it
    initial begin
        wait (table_ready === 1'b1);
        repeat (xfers.size() * (UART_FRAME_BITS * int'(max_div) + 20)) @(posedge clk);
        $display("Timeout: the transfers or serial frames did not finish in time");
        $display("Checks failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: compile.f
ahb_pkg.sv
ahb_multiplexor.sv
ahb_default_slave.sv
uart_tx_slave.sv
ahb_subsystem_top.sv
tb_ahb_subsystem.sv

// File: run.sh
#!/bin/sh
# Build the AHB subsystem testbench with Verilator and run it.
# The exit status of the simulation is the exit status of this script.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f compile.f \
    --top-module tb_ahb_subsystem --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb
